// ==== Makefile ====
TOP := tb_prefetch_buffer

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f

run: build
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASS"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f filelist.f

clean:
	rm -rf obj_dir

// ==== fetch_engine.sv ====
`timescale 1ns/1ps

module fetch_engine
  import fetch_mem_pkg::*;
  import fetch_instr_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,

  // core side
  input  logic        req_i,
  input  logic        branch_i,
  input  addr_t       addr_i,

  // space left in the word fifo
  input  logic        fifo_ready_i,

  // instruction memory
  output mem_req_t    mem_req_o,
  input  mem_rsp_t    mem_rsp_i,

  // fetched words toward the fifo
  output logic        push_o,
  output fifo_entry_t push_entry_o,

  output logic        busy_o
);

  fetch_state_e state_q, state_d;

  // address of the last request sent out
  addr_t        instr_addr_q;
  addr_t        fetch_addr;
  addr_t        branch_addr;
  logic         addr_valid;
  logic         start_fetch;

  // sequential fetch goes to the word after the last one
  assign fetch_addr  = {instr_addr_q[31:2], 2'b00} + WORD_BYTES;
  // memory only sees word addresses
  assign branch_addr = {addr_i[31:2], 2'b00};

  // a branch always fetches, otherwise only with room in the fifo
  assign start_fetch = (req_i & fifo_ready_i) | branch_i;

  // the word of a response belongs to the address last sent
  assign push_entry_o.addr       = instr_addr_q;
  assign push_entry_o.data.instr = mem_rsp_i.rdata;

  assign busy_o = (state_q != FETCH_IDLE) | mem_req_o.req;

  ////////////////////////////////
  // fetch fsm
  ////////////////////////////////

  always_comb begin
    mem_req_o.req  = 1'b0;
    mem_req_o.addr = fetch_addr;
    push_o         = 1'b0;
    addr_valid     = 1'b0;
    state_d        = state_q;

    unique case (state_q)
      // nothing outstanding
      FETCH_IDLE: begin
        if (branch_i) begin
          mem_req_o.addr = branch_addr;
        end
        if (start_fetch) begin
          mem_req_o.req = 1'b1;
          addr_valid    = 1'b1;
          state_d       = mem_rsp_i.gnt ? FETCH_WAIT_RSP : FETCH_WAIT_GNT;
        end
      end

      // request is out, hold it until granted
      FETCH_WAIT_GNT: begin
        mem_req_o.req  = 1'b1;
        mem_req_o.addr = instr_addr_q;
        // a branch still replaces the address before the grant
        if (branch_i) begin
          mem_req_o.addr = branch_addr;
          addr_valid     = 1'b1;
        end
        state_d = mem_rsp_i.gnt ? FETCH_WAIT_RSP : FETCH_WAIT_GNT;
      end

      // granted, waiting for the word
      FETCH_WAIT_RSP: begin
        if (branch_i) begin
          mem_req_o.addr = branch_addr;
        end
        if (mem_rsp_i.rvalid) begin
          // word of the old stream is dropped on a branch
          push_o = ~branch_i;
          // next request may go out in the response cycle
          if (start_fetch) begin
            mem_req_o.req = 1'b1;
            addr_valid    = 1'b1;
            state_d       = mem_rsp_i.gnt ? FETCH_WAIT_RSP : FETCH_WAIT_GNT;
          end else begin
            state_d = FETCH_IDLE;
          end
        end else if (branch_i) begin
          // remember the target, wait out the stale response
          addr_valid = 1'b1;
          state_d    = FETCH_WAIT_ABORTED;
        end
      end

      // stale response pending, its word goes nowhere
      FETCH_WAIT_ABORTED: begin
        mem_req_o.addr = instr_addr_q;
        if (branch_i) begin
          mem_req_o.addr = branch_addr;
          addr_valid     = 1'b1;
        end
        // target was stored already, send it once the old word is back
        if (mem_rsp_i.rvalid) begin
          mem_req_o.req = 1'b1;
          state_d       = mem_rsp_i.gnt ? FETCH_WAIT_RSP : FETCH_WAIT_GNT;
        end
      end

      default: begin
        state_d = FETCH_IDLE;
      end
    endcase
  end

  ////////////////////////////////
  // registers
  ////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= FETCH_IDLE;
      instr_addr_q <= '0;
    end else begin
      state_q <= state_d;
      if (addr_valid) begin
        instr_addr_q <= mem_req_o.addr;
      end
    end
  end

endmodule

// ==== fetch_instr_pkg.sv ====
package fetch_instr_pkg;

  import fetch_mem_pkg::*;

  ////////////////////////////////
  // instruction side types
  ////////////////////////////////

  // one 16-bit parcel, a compressed instruction or half of a full one
  typedef logic [15:0] parcel_t;

  // low two bits of a full 32-bit instruction
  localparam logic [1:0] FULL_OPCODE = 2'b11;

  // a fetched word, read as one instruction or as two parcels
  // hi sits in bits 31:16, lo in bits 15:0
  typedef union packed {
    word_t instr;
    struct packed {
      parcel_t hi;
      parcel_t lo;
    } parcels;
  } fetch_word_u;

  // fifo payload
  // addr is the word address the data was fetched from
  typedef struct packed {
    addr_t       addr;
    fetch_word_u data;
  } fifo_entry_t;

  ////////////////////////////////
  // compressed-parcel rule
  ////////////////////////////////

  // any opcode pattern other than 2'b11 starts a 16-bit instruction
  function automatic logic is_compressed(input parcel_t p);
    return p[1:0] != FULL_OPCODE;
  endfunction

endpackage

// ==== fetch_mem_pkg.sv ====
package fetch_mem_pkg;

  ////////////////////////////////
  // widths on the memory side
  ////////////////////////////////

  // byte address into instruction memory
  typedef logic [31:0] addr_t;

  // one word as read from memory
  typedef logic [31:0] word_t;

  // address step from one fetched word to the next
  localparam addr_t WORD_BYTES = 32'd4;

  ////////////////////////////////
  // request / grant / response
  ////////////////////////////////

  // request side, held until gnt is seen
  typedef struct packed {
    logic  req;
    addr_t addr;
  } mem_req_t;

  // gnt accepts the request, rvalid carries the word later
  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    word_t rdata;
  } mem_rsp_t;

  // fetch engine states
  // wait_aborted drops the response of a request that a branch made stale
  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_WAIT_GNT,
    FETCH_WAIT_RSP,
    FETCH_WAIT_ABORTED
  } fetch_state_e;

endpackage

// ==== filelist.f ====
fetch_mem_pkg.sv
fetch_instr_pkg.sv
fetch_engine.sv
word_fifo.sv
instr_aligner.sv
prefetch_buffer.sv
tb_clk_gen.sv
prefetch_buffer_asserts.sv
tb_prefetch_buffer.sv

// ==== instr_aligner.sv ====
`timescale 1ns/1ps

module instr_aligner
  import fetch_mem_pkg::*;
  import fetch_instr_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,

  // branch reloads the instruction address
  input  logic        branch_i,
  input  addr_t       addr_i,

  // fifo head and second word
  input  fifo_entry_t head_i,
  input  fifo_entry_t next_i,
  input  logic        head_valid_i,
  input  logic        next_valid_i,

  // core side
  input  logic        ready_i,
  output logic        valid_o,
  output word_t       rdata_o,
  output addr_t       addr_o,

  // head word is used up
  output logic        pop_o
);

  // address of the instruction being served
  addr_t addr_q;
  logic  compressed;
  logic  word_done;
  logic  avail;
  logic  xfer;

  assign addr_o = addr_q;

  ////////////////////////////////
  // parcel select
  ////////////////////////////////

  always_comb begin
    if (addr_q[1]) begin
      // upper half of the head word
      compressed = is_compressed(head_i.data.parcels.hi);
      // anything starting in the upper half ends this word
      word_done  = 1'b1;
      if (compressed) begin
        avail   = head_valid_i;
        rdata_o = {16'h0000, head_i.data.parcels.hi};
      end else begin
        // spans two words, needs the low parcel of the next one
        avail   = head_valid_i & next_valid_i;
        rdata_o = {next_i.data.parcels.lo, head_i.data.parcels.hi};
      end
    end else begin
      // lower half of the head word
      compressed = is_compressed(head_i.data.parcels.lo);
      avail      = head_valid_i;
      if (compressed) begin
        // upper parcel still to come from this word
        word_done = 1'b0;
        rdata_o   = {16'h0000, head_i.data.parcels.lo};
      end else begin
        word_done = 1'b1;
        rdata_o   = head_i.data.instr;
      end
    end
  end

  // fifo still holds the old stream in the branch cycle
  assign valid_o = avail & ~branch_i;
  assign xfer    = valid_o & ready_i;
  assign pop_o   = xfer & word_done;

  ////////////////////////////////
  // instruction address
  ////////////////////////////////

  // an unaligned 32-bit instruction keeps the halfword offset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else if (branch_i) begin
      addr_q <= addr_i;
    end else if (xfer) begin
      addr_q <= compressed ? addr_q + 32'd2 : addr_q + WORD_BYTES;
    end
  end

endmodule

// ==== prefetch_buffer.sv ====
`timescale 1ns/1ps

module prefetch_buffer
  import fetch_mem_pkg::*;
  import fetch_instr_pkg::*;
#(
  // word fifo slots, 3 or more
  parameter int DEPTH = 4
) (
  input  logic     clk,
  input  logic     rst_n,

  // core side
  input  logic     req_i,
  input  logic     branch_i,
  input  addr_t    addr_i,
  input  logic     ready_i,
  output logic     valid_o,
  output word_t    rdata_o,
  output addr_t    addr_o,
  output logic     busy_o,

  // instruction memory
  output mem_req_t mem_req_o,
  input  mem_rsp_t mem_rsp_i
);

  ////////////////////////////////
  // internal wires
  ////////////////////////////////

  logic        fifo_ready;
  logic        push;
  fifo_entry_t push_entry;
  logic        pop;
  fifo_entry_t head;
  logic        head_valid;
  fifo_entry_t next;
  logic        next_valid;

  // producer, talks to memory
  fetch_engine u_fetch_engine (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (req_i),
    .branch_i     (branch_i),
    .addr_i       (addr_i),
    .fifo_ready_i (fifo_ready),
    .mem_req_o    (mem_req_o),
    .mem_rsp_i    (mem_rsp_i),
    .push_o       (push),
    .push_entry_o (push_entry),
    .busy_o       (busy_o)
  );

  // buffer, a branch empties it for the next cycle
  word_fifo #(
    .DEPTH (DEPTH)
  ) u_word_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .clear_i      (branch_i),
    .push_i       (push),
    .push_entry_i (push_entry),
    .pop_i        (pop),
    .head_o       (head),
    .head_valid_o (head_valid),
    .next_o       (next),
    .next_valid_o (next_valid),
    .ready_o      (fifo_ready)
  );

  // consumer, serves the core
  instr_aligner u_instr_aligner (
    .clk          (clk),
    .rst_n        (rst_n),
    .branch_i     (branch_i),
    .addr_i       (addr_i),
    .head_i       (head),
    .next_i       (next),
    .head_valid_i (head_valid),
    .next_valid_i (next_valid),
    .ready_i      (ready_i),
    .valid_o      (valid_o),
    .rdata_o      (rdata_o),
    .addr_o       (addr_o),
    .pop_o        (pop)
  );

endmodule

// ==== prefetch_buffer_asserts.sv ====
`timescale 1ns/1ps

module prefetch_buffer_asserts
  import fetch_mem_pkg::*;
#(
  parameter int DEPTH = 4
) (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         branch_i,
  input  logic         ready_i,
  input  logic         out_valid_i,
  input  word_t        out_rdata_i,
  input  addr_t        out_addr_i,
  input  logic         busy_i,
  input  logic         push_i,
  input  logic         pop_i,
  input  mem_req_t     mem_req_i,
  input  mem_rsp_t     mem_rsp_i,
  input  fetch_state_e state_i
);

  // one sticky bit per property, the testbench polls any_fail
  logic req_held_fail = 1'b0;
  logic reset_fail    = 1'b0;
  logic stall_fail    = 1'b0;
  logic full_fail     = 1'b0;
  logic any_fail;

  // words held in the fifo, counted from push and pop alone
  int unsigned fill_q;

  assign any_fail = req_held_fail | reset_fail | stall_fail | full_fail;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fill_q <= 0;
    end else if (branch_i) begin
      fill_q <= 0;
    end else begin
      fill_q <= fill_q + (push_i ? 1 : 0) - (pop_i ? 1 : 0);
    end
  end

  //////////////////////////////
  // properties
  //////////////////////////////

  // ungranted request stays up with the same address, a branch may retarget it
  assert property (@(posedge clk) disable iff (!rst_n)
    (mem_req_i.req && !mem_rsp_i.gnt) |=>
      (mem_req_i.req && (branch_i || mem_req_i.addr == $past(mem_req_i.addr))))
  else begin
    $error("request address changed or request dropped before grant");
    req_held_fail = 1'b1;
  end

  // engine idle and not busy on the first edge out of reset
  assert property (@(posedge clk) $rose(rst_n) |-> (state_i == FETCH_IDLE && !busy_i))
  else begin
    $error("fetch engine busy right after reset");
    reset_fail = 1'b1;
  end

  // instruction on offer holds still while the core stalls
  assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid_i && !ready_i && !branch_i) |=>
      (branch_i || (out_valid_i && $stable(out_rdata_i) && $stable(out_addr_i))))
  else begin
    $error("instruction changed while the core was stalling");
    stall_fail = 1'b1;
  end

  // a full fifo only takes a word in the cycle it frees one
  assert property (@(posedge clk) disable iff (!rst_n)
    (push_i && fill_q == DEPTH) |-> pop_i)
  else begin
    $error("push into a full fifo");
    full_fail = 1'b1;
  end

endmodule

bind prefetch_buffer prefetch_buffer_asserts #(
  .DEPTH (DEPTH)
) u_asserts (
  .clk         (clk),
  .rst_n       (rst_n),
  .branch_i    (branch_i),
  .ready_i     (ready_i),
  .out_valid_i (valid_o),
  .out_rdata_i (rdata_o),
  .out_addr_i  (addr_o),
  .busy_i      (busy_o),
  .push_i      (push),
  .pop_i       (pop),
  .mem_req_i   (mem_req_o),
  .mem_rsp_i   (mem_rsp_i),
  .state_i     (u_fetch_engine.state_q)
);

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic rst_n
);

  // free running clock, first rising edge at half a period
  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // reset released a little after an edge, same as the other inputs
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2 rst_n = 1'b1;
  end

endmodule

// ==== tb_prefetch_buffer.sv ====
`timescale 1ns/1ps

module tb_prefetch_buffer
  import fetch_mem_pkg::*;
();

  localparam int NUM_XFERS = 1500;
  localparam int CLK_NS    = 40;
  // generous budget of 40 cycles per transfer
  localparam int LIMIT_NS  = NUM_XFERS * 40 * CLK_NS;

  logic     clk;
  logic     rst_n;
  logic     req_i;
  logic     branch_i;
  addr_t    addr_i;
  logic     ready_i;
  logic     valid_o;
  word_t    rdata_o;
  addr_t    addr_o;
  logic     busy_o;
  mem_req_t mem_req_o;
  mem_rsp_t mem_rsp_i;

  integer seed;
  // program image indexed by address bits 7:2
  word_t  prog [64];

  // memory model with at most one response pending
  logic   mem_pend;
  int     mem_wait;
  addr_t  mem_addr;
  addr_t  exp_req_addr;

  // reference model and core stimulus state
  addr_t  exp_addr;
  int     xfer_count;
  int     model_steps;
  int     since_branch;
  int     branch_gap;
  logic   want_abort;
  int     stall_left;

  tb_clk_gen #(
    .PERIOD_NS    (CLK_NS),
    .RESET_CYCLES (2)
  ) u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  prefetch_buffer u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_i     (req_i),
    .branch_i  (branch_i),
    .addr_i    (addr_i),
    .ready_i   (ready_i),
    .valid_o   (valid_o),
    .rdata_o   (rdata_o),
    .addr_o    (addr_o),
    .busy_o    (busy_o),
    .mem_req_o (mem_req_o),
    .mem_rsp_i (mem_rsp_i)
  );

  //////////////////////////////
  // helpers
  //////////////////////////////

  function automatic word_t rand_word();
    return $random(seed);
  endfunction

  function automatic int rand_below(input int n);
    return int'(rand_word() % n);
  endfunction

  // halfword of the program at byte address a
  function automatic logic [15:0] parcel_at(input addr_t a);
    word_t w;
    w = prog[a[7:2]];
    return a[1] ? w[31:16] : w[15:0];
  endfunction

  // only 2'b11 in the low bits opens a 32-bit instruction
  function automatic logic parcel_is_16bit(input logic [15:0] p);
    return p[1:0] != 2'b11;
  endfunction

  function automatic word_t expected_instr(input addr_t a);
    logic [15:0] lo;
    lo = parcel_at(a);
    if (parcel_is_16bit(lo)) begin
      return {16'h0000, lo};
    end
    return {parcel_at(a + 32'd2), lo};
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "run stopped at %0t ns", $time);
  endtask

  task automatic report_mismatch(input string name, input word_t got, input word_t exp);
    abort_run($sformatf("MISMATCH at %0t ns: %s got %08h expected %08h",
                        $time, name, got, exp));
  endtask

  //////////////////////////////
  // stimulus 2 ns after the rising edge
  //////////////////////////////

  task automatic drive_cycle();
    logic fire;
    // every other branch waits for a response in flight
    fire     = since_branch >= branch_gap && (mem_pend || !want_abort);
    branch_i = fire;
    if (fire) begin
      addr_i     = rand_word() & 32'hffff_fffe;
      branch_gap = 8 + rand_below(40);
      want_abort = ~want_abort;
    end
    req_i = rand_below(8) != 0;
    // short random gaps plus an occasional long stall
    if (stall_left > 0) begin
      ready_i = 1'b0;
      stall_left--;
    end else begin
      ready_i = rand_below(4) != 0;
      if (rand_below(32) == 0) begin
        stall_left = 10 + rand_below(30);
      end
    end
    mem_rsp_i.gnt    = rand_below(2) == 1;
    mem_rsp_i.rvalid = mem_pend && mem_wait == 1;
    mem_rsp_i.rdata  = mem_rsp_i.rvalid ? prog[mem_addr[7:2]] : rand_word();
  endtask

  //////////////////////////////
  // checks at the falling edge
  //////////////////////////////

  task automatic sample_cycle();
    word_t exp_data;
    logic  exp_busy;
    assert (!u_dut.u_asserts.any_fail)
      else abort_run("a protocol assertion on the DUT failed");
    // engine is busy while a request is up or a response is still owed
    exp_busy = mem_req_o.req || mem_pend;
    assert (busy_o == exp_busy) else report_mismatch("busy_o", busy_o, exp_busy);
    // every handshake counts but the model steps only outside a branch cycle
    if (valid_o && ready_i) begin
      xfer_count++;
    end
    if (branch_i) begin
      exp_addr     = addr_i;
      exp_req_addr = {addr_i[31:2], 2'b00};
      since_branch = 0;
    end else if (valid_o && ready_i) begin
      since_branch++;
      exp_data = expected_instr(exp_addr);
      assert (addr_o == exp_addr) else report_mismatch("addr_o", addr_o, exp_addr);
      assert (rdata_o == exp_data) else report_mismatch("rdata_o", rdata_o, exp_data);
      exp_addr = parcel_is_16bit(exp_data[15:0]) ? exp_addr + 32'd2 : exp_addr + 32'd4;
      model_steps++;
    end
    assert (xfer_count == model_steps)
      else report_mismatch("transfer count", xfer_count, model_steps);
    // memory side of the coming edge
    if (mem_rsp_i.rvalid) begin
      mem_pend = 1'b0;
    end else if (mem_pend) begin
      mem_wait--;
    end
    if (mem_req_o.req && mem_rsp_i.gnt) begin
      assert (!mem_pend) else abort_run("request granted while a response was outstanding");
      assert (mem_req_o.addr == exp_req_addr)
        else report_mismatch("mem_req_o.addr", mem_req_o.addr, exp_req_addr);
      mem_pend     = 1'b1;
      mem_addr     = mem_req_o.addr;
      mem_wait     = 1 + rand_below(3);
      exp_req_addr = exp_req_addr + 32'd4;
    end
  endtask

  initial begin
    seed         = 32'h38bb;
    req_i        = 1'b0;
    branch_i     = 1'b0;
    addr_i       = '0;
    ready_i      = 1'b0;
    mem_rsp_i    = '0;
    mem_pend     = 1'b0;
    mem_wait     = 0;
    mem_addr     = '0;
    exp_req_addr = '0;
    exp_addr     = '0;
    xfer_count   = 0;
    model_steps  = 0;
    since_branch = 0;
    branch_gap   = 0;
    want_abort   = 1'b0;
    stall_left   = 0;
    for (int i = 0; i < 64; i++) begin
      prog[i] = rand_word();
    end
    @(posedge rst_n);
    // quiet while req_i stays low
    repeat (4) begin
      @(negedge clk);
      assert (!mem_req_o.req && !valid_o && !busy_o)
        else abort_run("request, valid or busy active after reset with req_i low");
    end
    // the first drive cycle always branches since the stream has no start address yet
    while (xfer_count < NUM_XFERS) begin
      @(posedge clk);
      #2;
      drive_cycle();
      @(negedge clk);
      sample_cycle();
    end
    @(posedge clk);
    #2;
    branch_i = 1'b0;
    req_i    = 1'b0;
    ready_i  = 1'b0;
    @(negedge clk);
    assert (!u_dut.u_asserts.any_fail)
      else abort_run("a protocol assertion on the DUT failed");
    assert (addr_o == exp_addr) else report_mismatch("addr_o", addr_o, exp_addr);
    $display("TEST PASS");
    $finish;
  end

  // watchdog
  initial begin
    #(LIMIT_NS);
    abort_run($sformatf("watchdog expired at %0t ns with %0d of %0d transfers done",
                        $time, xfer_count, NUM_XFERS));
  end

endmodule

// ==== word_fifo.sv ====
`timescale 1ns/1ps

module word_fifo
  import fetch_instr_pkg::*;
#(
  // at least 3 so one slot stays free for the outstanding response
  parameter int DEPTH = 4
) (
  input  logic        clk,
  input  logic        rst_n,

  // drop all entries at the next edge
  input  logic        clear_i,

  // write side from the fetch engine
  input  logic        push_i,
  input  fifo_entry_t push_entry_i,

  // head word used up by the aligner
  input  logic        pop_i,

  // head and the word behind it toward the aligner
  output fifo_entry_t head_o,
  output logic        head_valid_o,
  output fifo_entry_t next_o,
  output logic        next_valid_o,

  output logic        ready_o
);

  // slot 0 is the head
  fifo_entry_t [DEPTH-1:0] entry_q, entry_d;
  logic        [DEPTH-1:0] valid_q, valid_d;
  logic                    placed;

  assign head_o       = entry_q[0];
  assign head_valid_o = valid_q[0];
  assign next_o       = entry_q[1];
  assign next_valid_o = valid_q[1];

  // stop new requests while the response in flight can still land
  assign ready_o = ~valid_q[DEPTH-2];

  ////////////////////////////////
  // shift and fill
  ////////////////////////////////

  always_comb begin
    entry_d = entry_q;
    valid_d = valid_q;
    placed  = 1'b0;

    // pop moves everything one slot toward the head
    if (pop_i) begin
      for (int i = 0; i < DEPTH - 1; i++) begin
        entry_d[i] = entry_q[i+1];
        valid_d[i] = valid_q[i+1];
      end
      valid_d[DEPTH-1] = 1'b0;
    end

    // push lands in the first free slot after the shift
    if (push_i) begin
      for (int i = 0; i < DEPTH; i++) begin
        if (!valid_d[i] && !placed) begin
          entry_d[i] = push_entry_i;
          valid_d[i] = 1'b1;
          placed     = 1'b1;
        end
      end
    end
  end

  ////////////////////////////////
  // registers
  ////////////////////////////////

  // valid bits of the slots
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (clear_i) begin
      // words of the old stream are gone after a branch
      valid_q <= '0;
    end else begin
      valid_q <= valid_d;
    end
  end

  // payload of the slots
  always_ff @(posedge clk) begin
    entry_q <= entry_d;
  end

endmodule
